//--- Bender.yml
package:
  name: kmac_app

sources:
  - source/kmac_app_pkg.sv
  - source/kmac_app_arbiter.sv
  - source/kmac_app_ctrl.sv
  - source/kmac_msg_mux.sv
  - source/kmac_app_rsp.sv
  - source/kmac_app.sv
  - target: simulation
    files:
      - verification/kmac_app_chk.sv
      - verification/kmac_app_tb.sv

//--- flist.f
source/kmac_app_pkg.sv
source/kmac_app_arbiter.sv
source/kmac_app_ctrl.sv
source/kmac_msg_mux.sv
source/kmac_app_rsp.sv
source/kmac_app.sv
verification/kmac_app_chk.sv
verification/kmac_app_tb.sv

//--- source/kmac_app.sv
// Top level of the keyed hash application front end
// Sets the client count and configurations and connects the
// arbiter, controller, message mux and response demux
`timescale 1ns/1ps

module kmac_app #(
  parameter int unsigned NumApp = 3,
  parameter kmac_app_pkg::app_cfg_t AppCfg [NumApp] = kmac_app_pkg::AppCfgDefault,
  localparam int IdxW = (NumApp > 1) ? $clog2(NumApp) : 1
) (
  input  logic                              clk_i,
  input  logic                              rst_ni,
  // Hardware clients
  input  logic                              app_valid_i [NumApp],
  input  logic [kmac_app_pkg::MsgWidth-1:0] app_data_i [NumApp],
  input  logic [kmac_app_pkg::MsgStrbW-1:0] app_strb_i [NumApp],
  input  logic                              app_last_i [NumApp],
  output logic                              app_ready_o [NumApp],
  output logic                              app_done_o [NumApp],
  output logic [kmac_app_pkg::DigestW-1:0]  app_digest_o [NumApp],
  output logic                              app_error_o [NumApp],
  // Core message port and digest
  output logic                              kmac_valid_o,
  output logic [kmac_app_pkg::MsgWidth-1:0] kmac_data_o,
  output logic [kmac_app_pkg::MsgWidth-1:0] kmac_mask_o,
  input  logic                              kmac_ready_i,
  input  logic [kmac_app_pkg::DigestW-1:0]  digest_i,
  // Software path
  input  logic                              sw_valid_i,
  input  logic [kmac_app_pkg::MsgWidth-1:0] sw_data_i,
  input  logic [kmac_app_pkg::MsgWidth-1:0] sw_mask_i,
  output logic                              sw_ready_o,
  input  kmac_app_pkg::kmac_cmd_e           sw_cmd_i,
  output kmac_app_pkg::kmac_cmd_e           cmd_o,
  input  logic                              absorbed_i,
  output logic                              absorbed_o,
  input  logic                              entropy_ready_i,
  output logic                              app_active_o,
  // Register and core configuration
  input  logic                              reg_kmac_en_i,
  input  kmac_app_pkg::sha3_mode_e          reg_sha3_mode_i,
  input  kmac_app_pkg::strength_e           reg_strength_i,
  output logic                              kmac_en_o,
  output kmac_app_pkg::sha3_mode_e          sha3_mode_o,
  output kmac_app_pkg::strength_e           strength_o
);

  logic                   arb_valid;
  logic [IdxW-1:0]        arb_idx;
  logic [IdxW-1:0]        app_id;
  logic                   set_appid;
  logic                   clr_appid;
  kmac_app_pkg::mux_sel_e mux_sel;
  logic                   fsm_ready;
  logic                   fsm_done_err;
  logic                   mux_app_ready;
  logic                   digest_done;

  kmac_app_arbiter #(.NumApp(NumApp)) u_arbiter (
    .clk_i, .rst_ni, .app_valid_i,
    .set_appid_i (set_appid),
    .clr_appid_i (clr_appid),
    .arb_valid_o (arb_valid),
    .arb_idx_o   (arb_idx),
    .app_id_o    (app_id)
  );

  kmac_app_ctrl #(.NumApp(NumApp), .AppCfg(AppCfg)) u_ctrl (
    .clk_i, .rst_ni,
    .arb_valid_i (arb_valid),
    .arb_idx_i   (arb_idx),
    .app_id_i    (app_id),
    .app_valid_i, .app_last_i,
    .app_ready_i (mux_app_ready),
    .kmac_valid_i (kmac_valid_o),
    .kmac_ready_i, .sw_cmd_i, .absorbed_i, .entropy_ready_i,
    .reg_kmac_en_i, .reg_sha3_mode_i, .reg_strength_i,
    .set_appid_o    (set_appid),
    .clr_appid_o    (clr_appid),
    .mux_sel_o      (mux_sel),
    .fsm_ready_o    (fsm_ready),
    .fsm_done_err_o (fsm_done_err),
    .digest_done_o  (digest_done),
    .cmd_o, .absorbed_o, .app_active_o,
    .kmac_en_o, .sha3_mode_o, .strength_o
  );

  kmac_msg_mux #(.NumApp(NumApp)) u_msg_mux (
    .app_id_i  (app_id),
    .mux_sel_i (mux_sel),
    .app_valid_i, .app_data_i, .app_strb_i,
    .sw_valid_i, .sw_data_i, .sw_mask_i, .kmac_ready_i,
    .kmac_valid_o, .kmac_data_o, .kmac_mask_o, .sw_ready_o,
    .mux_app_ready_o (mux_app_ready)
  );

  kmac_app_rsp #(.NumApp(NumApp)) u_rsp (
    .app_id_i        (app_id),
    .mux_app_ready_i (mux_app_ready),
    .fsm_ready_i     (fsm_ready),
    .fsm_done_err_i  (fsm_done_err),
    .digest_done_i   (digest_done),
    .digest_i,
    .app_ready_o, .app_done_o, .app_error_o, .app_digest_o
  );

endmodule

//--- source/kmac_app_arbiter.sv
// Fixed-priority arbiter over the hardware client requests
// Lowest index wins; the winner is latched as app_id on grant
// and held until the operation completes
`timescale 1ns/1ps

module kmac_app_arbiter #(
  parameter int unsigned NumApp = 3,
  localparam int IdxW = (NumApp > 1) ? $clog2(NumApp) : 1
) (
  input  logic            clk_i,
  input  logic            rst_ni,
  input  logic            app_valid_i [NumApp],
  input  logic            set_appid_i,
  input  logic            clr_appid_i,
  output logic            arb_valid_o,
  output logic [IdxW-1:0] arb_idx_o,
  output logic [IdxW-1:0] app_id_o
);

  // Priority encoder
  // Scan from the top so the lowest requester is the last one written
  always_comb begin
    arb_valid_o = 1'b0;
    arb_idx_o   = '0;
    for (int i = NumApp - 1; i >= 0; i--) begin
      if (app_valid_i[i]) begin
        arb_valid_o = 1'b1;
        arb_idx_o   = IdxW'(i);
      end
    end
  end

  // Granted client index
  // Clear wins over set, both come from the controller
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      app_id_o <= '0;
    end else if (clr_appid_i) begin
      app_id_o <= '0;
    end else if (set_appid_i) begin
      app_id_o <= arb_idx_o;
    end
  end

endmodule

//--- source/kmac_app_ctrl.sv
// Operation FSM of the application front end
// Sequences start, message, output length, process and done toward the core,
// selects the message source and keeps the core configuration registers
`timescale 1ns/1ps

module kmac_app_ctrl #(
  parameter int unsigned NumApp = 3,
  parameter kmac_app_pkg::app_cfg_t AppCfg [NumApp] = kmac_app_pkg::AppCfgDefault,
  localparam int IdxW = (NumApp > 1) ? $clog2(NumApp) : 1
) (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic                    arb_valid_i,
  input  logic [IdxW-1:0]         arb_idx_i,
  input  logic [IdxW-1:0]         app_id_i,
  input  logic                    app_valid_i [NumApp],
  input  logic                    app_last_i [NumApp],
  input  logic                    app_ready_i,
  input  logic                    kmac_valid_i,
  input  logic                    kmac_ready_i,
  input  kmac_app_pkg::kmac_cmd_e sw_cmd_i,
  input  logic                    absorbed_i,
  input  logic                    entropy_ready_i,
  input  logic                    reg_kmac_en_i,
  input  kmac_app_pkg::sha3_mode_e reg_sha3_mode_i,
  input  kmac_app_pkg::strength_e reg_strength_i,
  output logic                    set_appid_o,
  output logic                    clr_appid_o,
  output kmac_app_pkg::mux_sel_e  mux_sel_o,
  output logic                    fsm_ready_o,
  output logic                    fsm_done_err_o,
  output logic                    digest_done_o,
  output kmac_app_pkg::kmac_cmd_e cmd_o,
  output logic                    absorbed_o,
  output logic                    app_active_o,
  output logic                    kmac_en_o,
  output kmac_app_pkg::sha3_mode_e sha3_mode_o,
  output kmac_app_pkg::strength_e strength_o
);

  kmac_app_pkg::st_e st_q, st_d;
  logic              cur_kmac;
  logic              cur_last;

  // Mode of the granted client and its last-beat flag
  assign cur_kmac = (AppCfg[app_id_i].mode == kmac_app_pkg::AppKMAC);
  assign cur_last = app_valid_i[app_id_i] && app_last_i[app_id_i];

  ////////////////////////////////////////////////////////////
  // State register
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      st_q <= kmac_app_pkg::StIdle;
    end else begin
      st_q <= st_d;
    end
  end

  ////////////////////////////////////////////////////////////
  // Next state and outputs
  ////////////////////////////////////////////////////////////
  always_comb begin
    st_d           = st_q;
    mux_sel_o      = kmac_app_pkg::SelNone;
    set_appid_o    = 1'b0;
    clr_appid_o    = 1'b0;
    cmd_o          = kmac_app_pkg::CmdNone;
    absorbed_o     = 1'b0;
    fsm_ready_o    = 1'b0;
    fsm_done_err_o = 1'b0;
    digest_done_o  = 1'b0;
    unique case (st_q)
      kmac_app_pkg::StIdle: begin
        // Hardware clients take precedence over a software start
        if (arb_valid_i) begin
          set_appid_o = 1'b1;
          st_d        = kmac_app_pkg::StAppCfg;
        end else if (sw_cmd_i == kmac_app_pkg::CmdStart) begin
          cmd_o = kmac_app_pkg::CmdStart;
          st_d  = kmac_app_pkg::StSw;
        end
      end
      kmac_app_pkg::StAppCfg: begin
        // KMAC needs entropy, reject the request without touching the core
        if (cur_kmac && !entropy_ready_i) begin
          st_d = kmac_app_pkg::StError;
        end else begin
          cmd_o = kmac_app_pkg::CmdStart;
          st_d  = kmac_app_pkg::StAppMsg;
        end
      end
      kmac_app_pkg::StAppMsg: begin
        mux_sel_o = kmac_app_pkg::SelApp;
        if (cur_last && app_ready_i) begin
          st_d = cur_kmac ? kmac_app_pkg::StOutLen : kmac_app_pkg::StProcess;
        end
      end
      kmac_app_pkg::StOutLen: begin
        // Held here under core back-pressure
        mux_sel_o = kmac_app_pkg::SelOutLen;
        if (kmac_valid_i && kmac_ready_i) begin
          st_d = kmac_app_pkg::StProcess;
        end
      end
      kmac_app_pkg::StProcess: begin
        cmd_o = kmac_app_pkg::CmdProcess;
        st_d  = kmac_app_pkg::StWait;
      end
      kmac_app_pkg::StWait: begin
        if (absorbed_i) begin
          cmd_o         = kmac_app_pkg::CmdDone;
          digest_done_o = 1'b1;
          clr_appid_o   = 1'b1;
          st_d          = kmac_app_pkg::StIdle;
        end
      end
      kmac_app_pkg::StSw: begin
        mux_sel_o  = kmac_app_pkg::SelSw;
        cmd_o      = sw_cmd_i;
        absorbed_o = absorbed_i;
        if (sw_cmd_i == kmac_app_pkg::CmdDone) begin
          st_d = kmac_app_pkg::StIdle;
        end
      end
      kmac_app_pkg::StError: begin
        // Drain the rejected client up to its last beat
        fsm_ready_o = 1'b1;
        if (cur_last) begin
          st_d = kmac_app_pkg::StRejected;
        end
      end
      kmac_app_pkg::StRejected: begin
        fsm_done_err_o = 1'b1;
        clr_appid_o    = 1'b1;
        st_d           = kmac_app_pkg::StIdle;
      end
      default: st_d = kmac_app_pkg::StIdle;
    endcase
  end

  // Busy with a hardware client
  assign app_active_o = st_q inside {kmac_app_pkg::StAppCfg, kmac_app_pkg::StAppMsg,
                                     kmac_app_pkg::StOutLen, kmac_app_pkg::StProcess,
                                     kmac_app_pkg::StWait};

  ////////////////////////////////////////////////////////////
  // Core configuration
  ////////////////////////////////////////////////////////////
  // Client config loads on grant, register values otherwise
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      kmac_en_o   <= 1'b0;
      sha3_mode_o <= kmac_app_pkg::Sha3;
      strength_o  <= kmac_app_pkg::L256;
    end else if (set_appid_o) begin
      kmac_en_o   <= (AppCfg[arb_idx_i].mode == kmac_app_pkg::AppKMAC);
      sha3_mode_o <= (AppCfg[arb_idx_i].mode == kmac_app_pkg::AppSHA3)
                     ? kmac_app_pkg::Sha3 : kmac_app_pkg::CShake;
      strength_o  <= AppCfg[arb_idx_i].strength;
    end else if (clr_appid_o || st_q == kmac_app_pkg::StIdle) begin
      kmac_en_o   <= reg_kmac_en_i;
      sha3_mode_o <= reg_sha3_mode_i;
      strength_o  <= reg_strength_i;
    end
  end

endmodule

//--- source/kmac_app_pkg.sv
// Shared definitions for the keyed hash application front end
// Holds the widths, the command and mode encodings, the per-client
// configuration record and the right-encoded output length tables
package kmac_app_pkg;

  // Message beat and digest widths
  parameter int unsigned MsgWidth = 64;
  parameter int unsigned MsgStrbW = MsgWidth / 8;
  parameter int unsigned DigestW  = 256;
  parameter int unsigned OutLenW  = 24;

  typedef enum logic [1:0] {AppSHA3, AppCShake, AppKMAC} app_mode_e;

  typedef enum logic [0:0] {Sha3, CShake} sha3_mode_e;

  typedef enum logic [2:0] {L128, L224, L256, L384, L512} strength_e;

  typedef enum logic [1:0] {CmdNone, CmdStart, CmdProcess, CmdDone} kmac_cmd_e;

  typedef enum logic [1:0] {SelNone, SelApp, SelOutLen, SelSw} mux_sel_e;

  // Operation FSM states
  typedef enum logic [3:0] {
    StIdle, StAppCfg, StAppMsg, StOutLen, StProcess, StWait, StSw, StError, StRejected
  } st_e;

  // Fixed mode and strength of one hardware client
  typedef struct packed {
    app_mode_e mode;
    strength_e strength;
  } app_cfg_t;

  parameter app_cfg_t AppCfgDefault [3] = '{
    '{mode: AppKMAC,   strength: L256},
    '{mode: AppCShake, strength: L128},
    '{mode: AppSHA3,   strength: L512}
  };

  // right_encode(outlen), length byte sits in the MSB position
  function automatic logic [OutLenW-1:0] EncodedOutLen(int unsigned digest_w);
    case (digest_w)
      128:     return 24'h0001_80;
      192:     return 24'h0001_C0;
      384:     return 24'h02_8001;
      512:     return 24'h02_0002;
      default: return 24'h02_0001;
    endcase
  endfunction

  // Short encodings only fill two bytes
  function automatic logic [OutLenW-1:0] EncodedOutLenMask(int unsigned digest_w);
    return (digest_w inside {128, 192}) ? 24'h00FFFF : 24'hFFFFFF;
  endfunction

endpackage

//--- source/kmac_app_rsp.sv
// Response demux toward the hardware clients
// Only the granted client sees ready, done, error and digest;
// every other client reads zero
`timescale 1ns/1ps

module kmac_app_rsp #(
  parameter int unsigned NumApp = 3,
  localparam int IdxW = (NumApp > 1) ? $clog2(NumApp) : 1
) (
  input  logic [IdxW-1:0]                  app_id_i,
  input  logic                             mux_app_ready_i,
  input  logic                             fsm_ready_i,
  input  logic                             fsm_done_err_i,
  input  logic                             digest_done_i,
  input  logic [kmac_app_pkg::DigestW-1:0] digest_i,
  output logic                             app_ready_o [NumApp],
  output logic                             app_done_o [NumApp],
  output logic                             app_error_o [NumApp],
  output logic [kmac_app_pkg::DigestW-1:0] app_digest_o [NumApp]
);

  always_comb begin
    for (int i = 0; i < NumApp; i++) begin
      if (app_id_i == IdxW'(i)) begin
        // Data path ready in AppMsg, FSM ready while draining a rejected client
        app_ready_o[i]  = mux_app_ready_i | fsm_ready_i;
        // A done from the FSM is always the rejected case
        app_done_o[i]   = digest_done_i | fsm_done_err_i;
        app_error_o[i]  = fsm_done_err_i;
        // Digest only in the done cycle
        app_digest_o[i] = digest_done_i ? digest_i : '0;
      end else begin
        app_ready_o[i]  = 1'b0;
        app_done_o[i]   = 1'b0;
        app_error_o[i]  = 1'b0;
        app_digest_o[i] = '0;
      end
    end
  end

endmodule

//--- source/kmac_msg_mux.sv
// Message mux toward the core message port
// Selects the granted client, the output-length beat or software,
// expands client byte strobes to bit masks and returns ready to the source
`timescale 1ns/1ps

module kmac_msg_mux #(
  parameter int unsigned NumApp = 3,
  localparam int IdxW = (NumApp > 1) ? $clog2(NumApp) : 1
) (
  input  logic [IdxW-1:0]                   app_id_i,
  input  kmac_app_pkg::mux_sel_e            mux_sel_i,
  input  logic                              app_valid_i [NumApp],
  input  logic [kmac_app_pkg::MsgWidth-1:0] app_data_i [NumApp],
  input  logic [kmac_app_pkg::MsgStrbW-1:0] app_strb_i [NumApp],
  input  logic                              sw_valid_i,
  input  logic [kmac_app_pkg::MsgWidth-1:0] sw_data_i,
  input  logic [kmac_app_pkg::MsgWidth-1:0] sw_mask_i,
  input  logic                              kmac_ready_i,
  output logic                              kmac_valid_o,
  output logic [kmac_app_pkg::MsgWidth-1:0] kmac_data_o,
  output logic [kmac_app_pkg::MsgWidth-1:0] kmac_mask_o,
  output logic                              sw_ready_o,
  output logic                              mux_app_ready_o
);

  // Encoded output length for the client digest size
  localparam logic [kmac_app_pkg::OutLenW-1:0] OutLen =
      kmac_app_pkg::EncodedOutLen(kmac_app_pkg::DigestW);
  localparam logic [kmac_app_pkg::OutLenW-1:0] OutLenMask =
      kmac_app_pkg::EncodedOutLenMask(kmac_app_pkg::DigestW);

  always_comb begin
    kmac_valid_o    = 1'b0;
    kmac_data_o     = '0;
    kmac_mask_o     = '0;
    mux_app_ready_o = 1'b0;
    // Software beats are swallowed unless software owns the port
    sw_ready_o      = 1'b1;
    unique case (mux_sel_i)
      kmac_app_pkg::SelApp: begin
        kmac_valid_o = app_valid_i[app_id_i];
        kmac_data_o  = app_data_i[app_id_i];
        // One strobe bit covers one byte
        for (int i = 0; i < kmac_app_pkg::MsgStrbW; i++) begin
          kmac_mask_o[8*i+:8] = {8{app_strb_i[app_id_i][i]}};
        end
        mux_app_ready_o = kmac_ready_i;
      end
      kmac_app_pkg::SelOutLen: begin
        // Constant beat, valid held until it transfers
        kmac_valid_o = 1'b1;
        kmac_data_o  = kmac_app_pkg::MsgWidth'(OutLen);
        kmac_mask_o  = kmac_app_pkg::MsgWidth'(OutLenMask);
      end
      kmac_app_pkg::SelSw: begin
        kmac_valid_o = sw_valid_i;
        kmac_data_o  = sw_data_i;
        kmac_mask_o  = sw_mask_i;
        sw_ready_o   = kmac_ready_i;
      end
      default: begin
        kmac_valid_o = 1'b0;
      end
    endcase
  end

endmodule

//--- verification/kmac_app_chk.sv
// Concurrent checks bound into the application front end top level
// Client ready one-hot, single-cycle process command and held output-length beat
`timescale 1ns/1ps

module kmac_app_chk #(
  parameter int unsigned NumApp = 3
) (
  input logic                    clk_i,
  input logic                    rst_ni,
  input logic                    app_ready_o [NumApp],
  input kmac_app_pkg::kmac_cmd_e cmd_o,
  input logic                    kmac_valid_o,
  input logic                    kmac_ready_i,
  input kmac_app_pkg::mux_sel_e  mux_sel_i
);

  logic [NumApp-1:0] ready_vec;
  // Number of failed assertions
  int                fail_cnt = 0;

  always_comb begin
    for (int i = 0; i < NumApp; i++) begin
      ready_vec[i] = app_ready_o[i];
    end
  end

  ready_onehot: assert property (@(posedge clk_i) disable iff (!rst_ni) $onehot0(ready_vec))
    else begin
      $error("more than one client sees ready");
      fail_cnt++;
    end

  process_pulse: assert property (@(posedge clk_i) disable iff (!rst_ni)
      cmd_o == kmac_app_pkg::CmdProcess |=> cmd_o != kmac_app_pkg::CmdProcess)
    else begin
      $error("process command longer than one cycle");
      fail_cnt++;
    end

  // Output-length beat stays valid until the core takes it
  outlen_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
      (mux_sel_i == kmac_app_pkg::SelOutLen && kmac_valid_o && !kmac_ready_i)
      |=> (mux_sel_i == kmac_app_pkg::SelOutLen && kmac_valid_o))
    else begin
      $error("output-length beat dropped before transfer");
      fail_cnt++;
    end

endmodule

bind kmac_app kmac_app_chk #(.NumApp(NumApp)) u_chk (
  .clk_i, .rst_ni, .app_ready_o, .cmd_o, .kmac_valid_o, .kmac_ready_i,
  .mux_sel_i (mux_sel)
);

//--- verification/kmac_app_tb.sv
// Testbench for the keyed hash application front end
// Serves random client requests against a core-side model, runs the
// rejection and software paths and checks every core beat and response
`timescale 1ns/1ps

module kmac_app_tb;

  localparam int NumApp = 3;
  localparam logic [31:0] Seed = 32'h5b58d9b0;
  // About 25 operations of well under 160 cycles each with back-pressure
  localparam int MaxCycles = 25 * 160;

  // Client 0 is KMAC/L256, client 1 cSHAKE/L128 and client 2 SHA3/L512
  localparam logic KmacClient [NumApp] = '{1'b1, 1'b0, 1'b0};
  localparam kmac_app_pkg::sha3_mode_e ExpMode [NumApp] =
      '{kmac_app_pkg::CShake, kmac_app_pkg::CShake, kmac_app_pkg::Sha3};
  localparam kmac_app_pkg::strength_e ExpStrength [NumApp] =
      '{kmac_app_pkg::L256, kmac_app_pkg::L128, kmac_app_pkg::L512};

  logic clk_i, rst_ni;
  logic app_valid_i [NumApp];
  logic [kmac_app_pkg::MsgWidth-1:0] app_data_i [NumApp];
  logic [kmac_app_pkg::MsgStrbW-1:0] app_strb_i [NumApp];
  logic app_last_i [NumApp];
  logic app_ready_o [NumApp];
  logic app_done_o [NumApp];
  logic [kmac_app_pkg::DigestW-1:0] app_digest_o [NumApp];
  logic app_error_o [NumApp];
  logic kmac_valid_o, kmac_ready_i;
  logic [kmac_app_pkg::MsgWidth-1:0] kmac_data_o, kmac_mask_o;
  logic [kmac_app_pkg::DigestW-1:0] digest_i;
  logic sw_valid_i, sw_ready_o;
  logic [kmac_app_pkg::MsgWidth-1:0] sw_data_i, sw_mask_i;
  kmac_app_pkg::kmac_cmd_e sw_cmd_i, cmd_o;
  logic absorbed_i, absorbed_o, entropy_ready_i, app_active_o;
  logic reg_kmac_en_i, kmac_en_o;
  kmac_app_pkg::sha3_mode_e reg_sha3_mode_i, sha3_mode_o;
  kmac_app_pkg::strength_e reg_strength_i, strength_o;

  // Reference model queues filled on the falling edge and drained on the rising edge
  logic [63:0] exp_data [$];
  logic [63:0] exp_mask [$];
  kmac_app_pkg::kmac_cmd_e exp_cmd [$];
  int exp_done_id [$];
  logic exp_done_err [$];

  logic [31:0] lfsr;
  int wait_cnt, done_cnt, cycles;
  int errors, err_mark, tests_run, tests_failed;
  int chk_seen;

  kmac_app dut (.*);

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  ////////////////////////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////////////////////////
  // Galois LFSR stepped once per bit taken
  function automatic logic [63:0] rand_bits(input int n);
    logic [63:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'hD000_0001) : (lfsr >> 1);
      v[i] = lfsr[0];
    end
    return v;
  endfunction

  // One strobe bit stands for one byte
  function automatic logic [63:0] strb_to_mask(input logic [7:0] strb);
    logic [63:0] m;
    for (int b = 0; b < 8; b++) begin
      m[8*b+:8] = strb[b] ? 8'hFF : 8'h00;
    end
    return m;
  endfunction

  task automatic value_error(input string msg);
    errors++;
    $display("Error at %0t ns: %s", $time, msg);
  endtask

  task automatic other_failure(input string msg);
    errors++;
    $display("%s", msg);
  endtask

  // Core-side model with random ready and absorbed 2 to 9 cycles after a process command
  task automatic core_step();
    kmac_ready_i = (rand_bits(2) != 0);
    absorbed_i   = 1'b0;
    if (wait_cnt > 0) begin
      wait_cnt--;
      if (wait_cnt == 0) begin
        absorbed_i = 1'b1;
        for (int k = 0; k < 4; k++) begin
          digest_i[64*k+:64] = rand_bits(64);
        end
      end
    end else if (cmd_o == kmac_app_pkg::CmdProcess) begin
      wait_cnt = 2 + int'(rand_bits(3));
    end
  endtask

  task automatic end_test(input string name);
    if (dut.u_chk.fail_cnt != chk_seen) begin
      other_failure($sformatf("%s: %0d assertion failures in the bound checker", name,
                              dut.u_chk.fail_cnt - chk_seen));
      chk_seen = dut.u_chk.fail_cnt;
    end
    if (exp_data.size() != 0 || exp_cmd.size() != 0 || exp_done_id.size() != 0) begin
      other_failure($sformatf("%s: expected beats, commands or responses never came", name));
    end
    exp_data.delete();
    exp_mask.delete();
    exp_cmd.delete();
    exp_done_id.delete();
    exp_done_err.delete();
    tests_run++;
    if (errors != err_mark) begin
      tests_failed++;
    end
    $display("test %-26s %s, %0d errors", name, (errors == err_mark) ? "passed" : "failed",
             errors - err_mark);
    err_mark = errors;
  endtask

  ////////////////////////////////////////////////////////////
  // Client operations
  ////////////////////////////////////////////////////////////
  // All clients in req ask at once and are served by ascending index
  task automatic serve(input logic [NumApp-1:0] req, input logic ent_ok);
    logic [63:0] data [NumApp][4];
    logic [7:0]  strb [NumApp][4];
    int          nb [NumApp];
    int          pos [NumApp];
    logic        active [NumApp];
    logic        rejected;
    int          goal;
    goal            = done_cnt;
    entropy_ready_i = ent_ok;
    for (int c = 0; c < NumApp; c++) begin
      active[c] = req[c];
      pos[c]    = 0;
      nb[c]     = 1 + int'(rand_bits(2));
      if (req[c]) begin
        // KMAC without entropy is drained and never reaches the core
        rejected = KmacClient[c] && !ent_ok;
        if (!rejected) begin
          exp_cmd.push_back(kmac_app_pkg::CmdStart);
        end
        for (int b = 0; b < nb[c]; b++) begin
          data[c][b] = rand_bits(64);
          strb[c][b] = 8'(rand_bits(8));
          if (!rejected) begin
            exp_data.push_back(data[c][b]);
            exp_mask.push_back(strb_to_mask(strb[c][b]));
          end
        end
        if (!rejected && KmacClient[c]) begin
          // right_encode(256) after the last beat
          exp_data.push_back(64'h0000_0000_0002_0001);
          exp_mask.push_back(64'h0000_0000_00FF_FFFF);
        end
        if (!rejected) begin
          exp_cmd.push_back(kmac_app_pkg::CmdProcess);
          exp_cmd.push_back(kmac_app_pkg::CmdDone);
        end
        exp_done_id.push_back(c);
        exp_done_err.push_back(rejected);
        goal++;
      end
    end
    while (1) begin
      @(negedge clk_i);
      core_step();
      if (done_cnt == goal) break;
      for (int c = 0; c < NumApp; c++) begin
        app_valid_i[c] = active[c];
        app_data_i[c]  = active[c] ? data[c][pos[c]] : '0;
        app_strb_i[c]  = active[c] ? strb[c][pos[c]] : '0;
        app_last_i[c]  = active[c] && (pos[c] == nb[c] - 1);
      end
      @(posedge clk_i);
      for (int c = 0; c < NumApp; c++) begin
        if (active[c] && app_ready_o[c]) begin
          if (pos[c] == nb[c] - 1) active[c] = 1'b0;
          else pos[c]++;
        end
      end
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Software path
  ////////////////////////////////////////////////////////////
  task automatic sw_check();
    if (sw_ready_o !== kmac_ready_i) value_error("sw_ready_o does not follow kmac_ready_i");
    if (absorbed_o !== absorbed_i) value_error("absorbed_o does not follow absorbed_i");
  endtask

  task automatic sw_session();
    int   beats;
    int   sent;
    logic got;
    @(negedge clk_i);
    core_step();
    reg_kmac_en_i   = 1'(rand_bits(1));
    reg_sha3_mode_i = kmac_app_pkg::sha3_mode_e'(1'(rand_bits(1)));
    reg_strength_i  = kmac_app_pkg::strength_e'(3'(rand_bits(2)));
    // Idle registers pick the inputs up one edge later
    @(negedge clk_i);
    core_step();
    if (kmac_en_o !== reg_kmac_en_i || sha3_mode_o !== reg_sha3_mode_i ||
        strength_o !== reg_strength_i) begin
      value_error("idle configuration does not follow the register inputs");
    end
    sw_cmd_i = kmac_app_pkg::CmdStart;
    exp_cmd.push_back(kmac_app_pkg::CmdStart);
    beats = 2 + int'(rand_bits(2));
    sent  = 0;
    while (sent < beats) begin
      @(negedge clk_i);
      core_step();
      sw_cmd_i   = kmac_app_pkg::CmdNone;
      sw_valid_i = 1'b1;
      sw_data_i  = rand_bits(64);
      sw_mask_i  = rand_bits(64);
      if (kmac_ready_i) begin
        exp_data.push_back(sw_data_i);
        exp_mask.push_back(sw_mask_i);
        sent++;
      end
      @(posedge clk_i);
      sw_check();
    end
    @(negedge clk_i);
    core_step();
    sw_valid_i = 1'b0;
    sw_cmd_i   = kmac_app_pkg::CmdProcess;
    exp_cmd.push_back(kmac_app_pkg::CmdProcess);
    got = 1'b0;
    while (!got) begin
      @(negedge clk_i);
      core_step();
      sw_cmd_i = kmac_app_pkg::CmdNone;
      @(posedge clk_i);
      sw_check();
      got = absorbed_o;
    end
    @(negedge clk_i);
    core_step();
    sw_cmd_i = kmac_app_pkg::CmdDone;
    exp_cmd.push_back(kmac_app_pkg::CmdDone);
    @(negedge clk_i);
    core_step();
    sw_cmd_i = kmac_app_pkg::CmdNone;
  endtask

  ////////////////////////////////////////////////////////////
  // Monitor and timeout
  ////////////////////////////////////////////////////////////
  always @(posedge clk_i) begin : monitor
    int g;
    cycles++;
    if (cycles >= MaxCycles) begin
      $display("Timeout: the run did not finish within %0d cycles", MaxCycles);
      $display("FAIL: see errors above");
      $finish;
    end else if (rst_ni) begin
      // Core beats in order
      if (kmac_valid_o && kmac_ready_i) begin
        if (exp_data.size() == 0) begin
          value_error($sformatf("unexpected core beat %h", kmac_data_o));
        end else if (kmac_data_o !== exp_data[0] || kmac_mask_o !== exp_mask[0]) begin
          value_error($sformatf("core beat %h mask %h, expected %h mask %h",
                                kmac_data_o, kmac_mask_o, exp_data[0], exp_mask[0]));
        end
        if (exp_data.size() != 0) begin
          void'(exp_data.pop_front());
          void'(exp_mask.pop_front());
        end
      end
      // Command sequence
      if (cmd_o != kmac_app_pkg::CmdNone) begin
        if (exp_cmd.size() == 0 || cmd_o != exp_cmd[0]) begin
          value_error($sformatf("unexpected command %s", cmd_o.name()));
        end else begin
          void'(exp_cmd.pop_front());
        end
      end
      // Head of the response queue is the granted client
      g = (exp_done_id.size() != 0) ? exp_done_id[0] : -1;
      if (app_active_o) begin
        if (g < 0) begin
          value_error("app_active_o high with no client waiting");
        end else if (kmac_en_o !== KmacClient[g] || sha3_mode_o !== ExpMode[g] ||
                     strength_o !== ExpStrength[g]) begin
          value_error($sformatf("core configuration wrong for client %0d", g));
        end
        if (!sw_ready_o) value_error("sw_ready_o low while a client is served");
      end
      for (int i = 0; i < NumApp; i++) begin
        if (i != g) begin
          if (app_ready_o[i] || app_done_o[i] || app_error_o[i] || app_digest_o[i] != '0) begin
            value_error($sformatf("client %0d sees a response while not granted", i));
          end
        end else if (app_done_o[i]) begin
          if (app_error_o[i] !== exp_done_err[0]) begin
            value_error($sformatf("client %0d error %b, expected %b", i, app_error_o[i],
                                  exp_done_err[0]));
          end
          if (!exp_done_err[0] && (!absorbed_i || app_digest_o[i] !== digest_i)) begin
            value_error($sformatf("client %0d digest wrong or done before absorbed", i));
          end
          if (exp_done_err[0] && app_digest_o[i] != '0) begin
            value_error($sformatf("client %0d got a digest on rejection", i));
          end
          void'(exp_done_id.pop_front());
          void'(exp_done_err.pop_front());
          done_cnt++;
        end else if (app_error_o[i]) begin
          value_error($sformatf("client %0d error without done", i));
        end
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////////////////////////
  initial begin : main
    logic [NumApp-1:0] req;
    lfsr = Seed;
    for (int c = 0; c < NumApp; c++) begin
      app_valid_i[c] = 1'b0;
      app_data_i[c]  = '0;
      app_strb_i[c]  = '0;
      app_last_i[c]  = 1'b0;
    end
    kmac_ready_i    = 1'b0;
    digest_i        = '0;
    sw_valid_i      = 1'b0;
    sw_data_i       = '0;
    sw_mask_i       = '0;
    sw_cmd_i        = kmac_app_pkg::CmdNone;
    absorbed_i      = 1'b0;
    entropy_ready_i = 1'b1;
    reg_kmac_en_i   = 1'b0;
    reg_sha3_mode_i = kmac_app_pkg::Sha3;
    reg_strength_i  = kmac_app_pkg::L128;
    wait_cnt = 0;
    done_cnt = 0;
    cycles   = 0;
    errors   = 0;
    err_mark = 0;
    chk_seen = 0;
    rst_ni   = 1'b0;
    repeat (8) @(negedge clk_i);
    if (cmd_o != kmac_app_pkg::CmdNone || kmac_valid_o || absorbed_o || app_active_o) begin
      value_error("outputs not idle in reset");
    end
    for (int c = 0; c < NumApp; c++) begin
      if (app_ready_o[c] || app_done_o[c] || app_error_o[c]) begin
        value_error($sformatf("client %0d outputs not idle in reset", c));
      end
    end
    rst_ni = 1'b1;
    end_test("reset");
    for (int r = 0; r < 2; r++) begin
      for (int c = 0; c < NumApp; c++) begin
        serve(NumApp'(1 << c), 1'b1);
      end
    end
    end_test("forwarding and digest");
    for (int r = 0; r < 6; r++) begin
      req = NumApp'(rand_bits(NumApp));
      if (r < 2 || req == '0) req = '1;
      serve(req, 1'b1);
    end
    end_test("priority");
    serve(3'b001, 1'b0);
    serve(3'b011, 1'b0);
    end_test("rejection");
    sw_session();
    sw_session();
    end_test("software path");
    $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule
